//--- all.f
+incdir+common
common/len5_pkg.sv
common/expipe_pkg.sv
logic/modn_counter.sv
rob/rob.sv
logic/commit_cu.sv
logic/arch_state.sv
logic/backend_top.sv
dv/tb_backend.sv

//--- common/expipe_pkg.sv
/*
 * Execution pipeline types shared by the reorder buffer, the commit
 * unit and the architectural state
 */

package expipe_pkg;

    import len5_pkg::*;

    // Widest buffer index any configuration may use
    localparam int MAX_ROB_IDX_LEN = 4;

    // Exception causes, RISC-V mcause encoding
    typedef enum logic [3:0] {
        E_ILLEGAL_INSTRUCTION = 4'h2,
        E_LD_ADDR_MISALIGNED  = 4'h4,
        E_ST_ADDR_MISALIGNED  = 4'h6,
        E_ENV_CALL            = 4'hb
    } except_code_t;

    // One word, two readings: result normally, offending address on exception
    typedef union packed {
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] aux;
    } res_word_u;

    // --------------------
    // Result broadcast
    // --------------------
    typedef struct packed {
        logic [MAX_ROB_IDX_LEN-1:0] rob_idx;   // Low bits used by the buffer
        res_word_u                  res;
        logic                       except_raised;
        except_code_t               except_code;
    } cdb_data_t;

    // Buffer entry
    typedef struct packed {
        logic                   valid;
        logic                   res_ready;
        logic                   except_raised;
        instr_t                 instruction;
        logic [XLEN-1:0]        pc;
        logic [REG_IDX_LEN-1:0] rd_idx;
        res_word_u              res;
        except_code_t           except_code;
    } rob_entry_t;

endpackage

//--- common/len5_config.svh
/*
 * Core build switches for the execution back end
 */

`ifndef LEN5_CONFIG_SVH_
`define LEN5_CONFIG_SVH_

// Set to 1 to elaborate the RTL assertion blocks, 0 to leave them out
`define LEN5_ASSERT_EN 1

`endif // LEN5_CONFIG_SVH_

//--- common/len5_pkg.sv
/*
 * Core-wide widths and the raw instruction word
 */

package len5_pkg;

    // --------------------
    // Datapath widths
    // --------------------
    localparam int XLEN        = 32;    // Integer register width
    localparam int ILEN        = 32;    // Uncompressed instructions only
    localparam int REG_IDX_LEN = 5;     // x0..x31

    // Raw instruction word, kept undecoded past issue
    typedef logic [ILEN-1:0] instr_t;

endpackage

//--- dv/backend_trace.txt
# wt iv pc  rd ex cd val  rr cv ci cr s1 s2 rf msk rdy tl r1r r1v r2r r2v rfv  tv tc tpc taux
# all hex; msk bit 0 rdy 1 tl 2 r1r 3 r1v 4 r2r 5 r2v 6 rfv 7 tv 8 tc+tpc+taux; wt 1 waits for ready
0 0 000 00 0 2 0000 0 0 0 00 0 0 00 0d7 1 0 0 00 0 00 0000 0 0 000 0000
0 1 100 01 0 2 0000 0 0 0 00 0 0 00 083 1 0 0 00 0 00 0000 0 0 000 0000
0 1 104 02 0 2 0000 0 0 0 00 0 0 00 087 1 1 0 00 0 00 0000 0 0 000 0000
0 1 108 03 0 2 0000 0 0 0 00 0 1 00 097 1 2 0 00 0 00 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 1 2 33 2 0 00 097 1 3 0 00 0 00 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 1 0 11 2 0 00 09f 1 3 1 33 0 00 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 1 1 22 0 2 01 0bf 1 3 1 11 1 33 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 0 0 00 1 0 01 0df 1 3 1 22 0 00 0011 0 0 000 0000
0 0 000 00 0 2 0000 0 0 0 00 2 0 02 0cf 1 3 1 33 0 00 0022 0 0 000 0000
0 0 000 00 0 2 0000 0 0 0 00 2 0 03 0c7 1 3 0 00 0 00 0033 0 0 000 0000
0 1 10c 00 0 2 00ff 1 0 0 00 3 0 00 0c7 1 3 0 00 0 00 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 0 0 00 3 0 00 0cf 1 4 1 ff 0 00 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 0 0 00 3 0 00 0c7 1 4 0 00 0 00 0000 0 0 000 0000
0 1 200 04 0 2 0000 0 0 0 00 0 0 00 083 1 4 0 00 0 00 0000 0 0 000 0000
0 1 204 06 1 4 dead 0 0 0 00 0 0 00 083 1 5 0 00 0 00 0000 0 0 000 0000
0 1 208 01 0 2 0077 1 0 0 00 0 0 00 083 1 6 0 00 0 00 0000 0 0 000 0000
0 1 20c 07 0 2 0000 0 0 0 00 0 0 00 083 1 7 0 00 0 00 0000 0 0 000 0000
0 1 210 08 0 2 0000 0 0 0 00 0 0 00 083 1 0 0 00 0 00 0000 0 0 000 0000
0 1 214 09 0 2 0000 0 0 0 00 0 0 00 083 1 1 0 00 0 00 0000 0 0 000 0000
0 1 218 0a 0 2 0000 0 0 0 00 0 0 00 083 1 2 0 00 0 00 0000 0 0 000 0000
0 1 21c 0b 0 2 0000 0 0 0 00 0 0 00 083 1 3 0 00 0 00 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 0 0 00 6 0 00 08f 0 4 1 77 0 00 0000 0 0 000 0000
0 0 000 00 0 2 0000 0 1 4 44 0 0 00 083 0 4 0 00 0 00 0000 0 0 000 0000
1 0 000 00 0 2 0000 0 0 0 00 0 0 04 1c3 0 4 0 00 0 00 0044 1 4 204 dead
0 0 000 00 0 2 0000 0 0 0 00 6 0 01 1c7 1 0 0 00 0 00 0011 1 4 204 dead
0 1 400 05 0 2 0055 1 0 0 00 0 0 00 183 1 0 0 00 0 00 0000 1 4 204 dead
0 0 000 00 0 2 0000 0 0 0 00 0 0 00 18f 1 1 1 55 0 00 0000 1 4 204 dead
0 0 000 00 0 2 0000 0 0 0 00 0 0 05 1c3 1 1 0 00 0 00 0055 1 4 204 dead

//--- dv/tb_backend.sv
/*
 * Testbench for the execution back end. Replays one trace line per
 * cycle and checks the DUT outputs selected by each line's mask
 */
`timescale 1ns/100ps

module tb_backend;

    import len5_pkg::*;
    import expipe_pkg::*;

    localparam int ROB_DEPTH     = 8;
    localparam int ROB_IDX_LEN   = 3;
    localparam int READY_TIMEOUT = 50;              // Cycles
    localparam instr_t NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

    // --------------------
    // DUT signals
    // --------------------
    logic                   clk_i, rst_n_i;
    logic                   issue_valid_i, issue_ready_o;
    logic [ROB_IDX_LEN-1:0] issue_rs1_idx_i, issue_rs2_idx_i;
    logic                   issue_rs1_ready_o, issue_rs2_ready_o;
    logic [XLEN-1:0]        issue_rs1_value_o, issue_rs2_value_o;
    instr_t                 issue_instr_i;
    logic [XLEN-1:0]        issue_pc_i;
    logic [REG_IDX_LEN-1:0] issue_rd_idx_i;
    logic                   issue_except_raised_i;
    except_code_t           issue_except_code_i;
    logic [XLEN-1:0]        issue_except_aux_i;
    logic                   issue_res_ready_i;
    logic [XLEN-1:0]        issue_res_value_i;
    logic [ROB_IDX_LEN-1:0] issue_tail_idx_o;
    logic                   cdb_valid_i;
    cdb_data_t              cdb_data_i;
    logic                   comm_valid_o;               // Checked against the buffer model
    logic [REG_IDX_LEN-1:0] rf_rs_idx_i;
    logic [XLEN-1:0]        rf_rs_value_o;
    logic                   trap_valid_o;
    except_code_t           trap_cause_o;
    logic [XLEN-1:0]        trap_pc_o, trap_aux_o;

    // Trace columns, 2-state so the inputs start at zero
    bit [31:0] t_wait, t_iv, t_pc, t_rd, t_exc, t_code, t_val, t_rr;
    bit [31:0] t_cv, t_cidx, t_cres, t_rs1, t_rs2, t_rf, t_mask;
    bit [31:0] e_rdy, e_tail, e_r1r, e_r1v, e_r2r, e_r2v, e_rfv;
    bit [31:0] e_tv, e_tc, e_tpc, e_taux;
    int        fd, n_fields, steps;
    string     line;

    // Slot status as seen from the driven inputs alone
    bit [ROB_DEPTH-1:0] mdl_valid, mdl_done, mdl_trap;
    int                 mdl_head, mdl_tail;
    bit                 mdl_flush;                  // Cycle after a trap retires
    bit                 mdl_push, mdl_pop;

    backend_top #(
        .ROB_DEPTH   (ROB_DEPTH),
        .ROB_IDX_LEN (ROB_IDX_LEN)
    ) UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;              // 4 ns period
    end

    // --------------------
    // Buffer model
    // --------------------
    // In order retire, head complete means commit at the next edge
    always @(posedge clk_i) begin
        mdl_pop  = mdl_valid[mdl_head] && mdl_done[mdl_head] && !mdl_flush;
        mdl_push = issue_valid_i && !mdl_valid[mdl_tail] && !mdl_flush;
        if (!rst_n_i || mdl_flush) begin
            mdl_valid = '0;
            mdl_done  = '0;
            mdl_head  = 0;
            mdl_tail  = 0;
            mdl_flush = 1'b0;
        end else begin
            if (mdl_pop) begin
                mdl_valid[mdl_head] = 1'b0;
                mdl_flush           = mdl_trap[mdl_head];   // Trap drops the rest
                mdl_head            = (mdl_head + 1) % ROB_DEPTH;
            end
            if (mdl_push) begin
                mdl_valid[mdl_tail] = 1'b1;
                mdl_done[mdl_tail]  = issue_res_ready_i || issue_except_raised_i;
                mdl_trap[mdl_tail]  = issue_except_raised_i;
                mdl_tail            = (mdl_tail + 1) % ROB_DEPTH;
            end
            if (cdb_valid_i) begin
                mdl_done[cdb_data_i.rob_idx[ROB_IDX_LEN-1:0]] = 1'b1;
                mdl_trap[cdb_data_i.rob_idx[ROB_IDX_LEN-1:0]] = cdb_data_i.except_raised;
            end
        end
    end

    // --------------------
    // Driver
    // --------------------
    task automatic drive_inputs();
        issue_valid_i            = t_iv[0];
        issue_instr_i            = NOP_INSTR;
        issue_pc_i               = t_pc;
        issue_rd_idx_i           = t_rd[REG_IDX_LEN-1:0];
        issue_except_raised_i    = t_exc[0];
        issue_except_code_i      = except_code_t'(t_code[3:0]);
        issue_except_aux_i       = t_val;       // One column, two meanings
        issue_res_ready_i        = t_rr[0];
        issue_res_value_i        = t_val;
        cdb_valid_i              = t_cv[0];
        cdb_data_i.rob_idx       = t_cidx[MAX_ROB_IDX_LEN-1:0];
        cdb_data_i.res.result    = t_cres;
        cdb_data_i.except_raised = 1'b0;        // CDB traps not exercised
        cdb_data_i.except_code   = E_ILLEGAL_INSTRUCTION;
        issue_rs1_idx_i          = t_rs1[ROB_IDX_LEN-1:0];
        issue_rs2_idx_i          = t_rs2[ROB_IDX_LEN-1:0];
        rf_rs_idx_i              = t_rf[REG_IDX_LEN-1:0];
    endtask

    // Holds the bus idle until the buffer takes a push again
    task automatic wait_issue_ready();
        int cycles;
        cycles        = 0;
        issue_valid_i = 1'b0;
        cdb_valid_i   = 1'b0;
        #2.5;
        while (!issue_ready_o) begin
            assert (cycles < READY_TIMEOUT) else begin
                $display("timeout: issue_ready_o still low after %0d cycles", cycles);
                $display("Finished with errors");
                $fatal(1);
            end
            @(posedge clk_i);
            #3.5;                               // Same sample point as the checks
            cycles++;
        end
        @(posedge clk_i);
        #1;
    endtask

    // --------------------
    // Checker
    // --------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch at %0.1f ns: %s expected %h, got %h",
                     $realtime, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_outputs();
        check_value("comm_valid_o", mdl_valid[mdl_head] && mdl_done[mdl_head], comm_valid_o);
        if (t_mask[0]) check_value("issue_ready_o", e_rdy, issue_ready_o);
        if (t_mask[1]) check_value("issue_tail_idx_o", e_tail, issue_tail_idx_o);
        if (t_mask[2]) check_value("issue_rs1_ready_o", e_r1r, issue_rs1_ready_o);
        if (t_mask[3]) check_value("issue_rs1_value_o", e_r1v, issue_rs1_value_o);
        if (t_mask[4]) check_value("issue_rs2_ready_o", e_r2r, issue_rs2_ready_o);
        if (t_mask[5]) check_value("issue_rs2_value_o", e_r2v, issue_rs2_value_o);
        if (t_mask[6]) check_value("rf_rs_value_o", e_rfv, rf_rs_value_o);
        if (t_mask[7]) check_value("trap_valid_o", e_tv, trap_valid_o);
        if (t_mask[8]) begin                    // Whole trap record
            check_value("trap_cause_o", e_tc, trap_cause_o);
            check_value("trap_pc_o", e_tpc, trap_pc_o);
            check_value("trap_aux_o", e_taux, trap_aux_o);
        end
    endtask

    // --------------------
    // Trace replay
    // --------------------
    initial begin
        rst_n_i = 1'b0;
        steps   = 0;
        drive_inputs();                         // All zero before the first line
        fd = $fopen("dv/backend_trace.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the trace file dv/backend_trace.txt");
            $display("Finished with errors");
            $fatal(1);
        end
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;   // Header or blank
            n_fields = $sscanf(line,
                "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                t_wait, t_iv, t_pc, t_rd, t_exc, t_code, t_val, t_rr,
                t_cv, t_cidx, t_cres, t_rs1, t_rs2, t_rf, t_mask,
                e_rdy, e_tail, e_r1r, e_r1v, e_r2r, e_r2v, e_rfv,
                e_tv, e_tc, e_tpc, e_taux);
            assert (n_fields == 26) else begin
                $display("trace step %0d has %0d fields instead of 26", steps, n_fields);
                $display("Finished with errors");
                $fatal(1);
            end
            @(posedge clk_i);
            #1;
            if (t_wait[0]) wait_issue_ready();
            drive_inputs();
            #2.5;                               // Just before the next edge
            check_outputs();
            steps++;
        end
        $fclose(fd);
        $display("%0d trace steps replayed", steps);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- logic/arch_state.sv
/*
 * Architectural state: integer register file with x0 tied to zero,
 * and the record of the last retired trap
 */
`timescale 1ns/100ps

module arch_state (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             rf_we_i,
    input  logic [len5_pkg::REG_IDX_LEN-1:0] rf_rd_idx_i,
    input  expipe_pkg::res_word_u            rf_value_i,     // Result or trap aux
    input  logic                             trap_we_i,
    input  expipe_pkg::except_code_t         trap_code_i,
    input  logic [len5_pkg::XLEN-1:0]        trap_pc_i,
    input  logic [len5_pkg::REG_IDX_LEN-1:0] rf_rs_idx_i,
    output logic [len5_pkg::XLEN-1:0]        rf_rs_value_o,
    output logic                             trap_valid_o,
    output expipe_pkg::except_code_t         trap_cause_o,
    output logic [len5_pkg::XLEN-1:0]        trap_pc_o,
    output logic [len5_pkg::XLEN-1:0]        trap_aux_o
);

    import len5_pkg::*;

    logic [XLEN-1:0] rf [32];

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rf_we_i && (rf_rd_idx_i != '0)) begin   // x0 writes dropped
            rf[rf_rd_idx_i] <= rf_value_i.result;
        end
    end

    assign rf_rs_value_o = (rf_rs_idx_i == '0) ? '0 : rf[rf_rs_idx_i];

    // Trap record, the flag stays set once a trap retires
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trap_valid_o <= 1'b0;
        end else if (trap_we_i) begin
            trap_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (trap_we_i) begin
            trap_cause_o <= trap_code_i;
            trap_pc_o    <= trap_pc_i;
            trap_aux_o   <= rf_value_i.aux;     // Offending address view
        end
    end

endmodule

//--- logic/backend_top.sv
/*
 * Back-end top: reorder buffer, commit FSM and architectural state
 */
`timescale 1ns/100ps

module backend_top #(
    parameter int ROB_DEPTH   = 8,
    parameter int ROB_IDX_LEN = 3     // At most expipe_pkg::MAX_ROB_IDX_LEN
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             issue_valid_i,
    output logic                             issue_ready_o,
    input  logic [ROB_IDX_LEN-1:0]           issue_rs1_idx_i,
    input  logic [ROB_IDX_LEN-1:0]           issue_rs2_idx_i,
    output logic                             issue_rs1_ready_o,
    output logic                             issue_rs2_ready_o,
    output logic [len5_pkg::XLEN-1:0]        issue_rs1_value_o,
    output logic [len5_pkg::XLEN-1:0]        issue_rs2_value_o,
    input  len5_pkg::instr_t                 issue_instr_i,
    input  logic [len5_pkg::XLEN-1:0]        issue_pc_i,
    input  logic [len5_pkg::REG_IDX_LEN-1:0] issue_rd_idx_i,
    input  logic                             issue_except_raised_i,
    input  expipe_pkg::except_code_t         issue_except_code_i,
    input  logic [len5_pkg::XLEN-1:0]        issue_except_aux_i,
    input  logic                             issue_res_ready_i,
    input  logic [len5_pkg::XLEN-1:0]        issue_res_value_i,
    output logic [ROB_IDX_LEN-1:0]           issue_tail_idx_o,
    input  logic                             cdb_valid_i,
    input  expipe_pkg::cdb_data_t            cdb_data_i,
    output logic                             comm_valid_o,
    input  logic [len5_pkg::REG_IDX_LEN-1:0] rf_rs_idx_i,
    output logic [len5_pkg::XLEN-1:0]        rf_rs_value_o,
    output logic                             trap_valid_o,
    output expipe_pkg::except_code_t         trap_cause_o,
    output logic [len5_pkg::XLEN-1:0]        trap_pc_o,
    output logic [len5_pkg::XLEN-1:0]        trap_aux_o
);

    import len5_pkg::*;
    import expipe_pkg::*;

    // --------------------
    // Commit path wires
    // --------------------
    logic                   comm_ready, comm_except_raised;
    logic                   rf_we, trap_we, flush;
    logic [XLEN-1:0]        comm_pc;
    logic [REG_IDX_LEN-1:0] comm_rd_idx;
    res_word_u              comm_value;         // Result or aux, by except flag
    except_code_t           comm_except_code;

    rob #(
        .ROB_DEPTH   (ROB_DEPTH),
        .ROB_IDX_LEN (ROB_IDX_LEN)
    ) u_rob (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .flush_i               (flush),
        .issue_valid_i         (issue_valid_i),
        .issue_ready_o         (issue_ready_o),
        .issue_rs1_idx_i       (issue_rs1_idx_i),
        .issue_rs2_idx_i       (issue_rs2_idx_i),
        .issue_rs1_ready_o     (issue_rs1_ready_o),
        .issue_rs2_ready_o     (issue_rs2_ready_o),
        .issue_rs1_value_o     (issue_rs1_value_o),
        .issue_rs2_value_o     (issue_rs2_value_o),
        .issue_instr_i         (issue_instr_i),
        .issue_pc_i            (issue_pc_i),
        .issue_rd_idx_i        (issue_rd_idx_i),
        .issue_except_raised_i (issue_except_raised_i),
        .issue_except_code_i   (issue_except_code_i),
        .issue_except_aux_i    (issue_except_aux_i),
        .issue_res_ready_i     (issue_res_ready_i),
        .issue_res_value_i     (issue_res_value_i),
        .issue_tail_idx_o      (issue_tail_idx_o),
        .cdb_valid_i           (cdb_valid_i),
        .cdb_data_i            (cdb_data_i),
        .comm_ready_i          (comm_ready),
        .comm_valid_o          (comm_valid_o),
        .comm_instr_o          (),              // No decode at commit yet
        .comm_pc_o             (comm_pc),
        .comm_rd_idx_o         (comm_rd_idx),
        .comm_value_o          (comm_value),
        .comm_except_raised_o  (comm_except_raised),
        .comm_except_code_o    (comm_except_code),
        .comm_head_idx_o       ()               // For rename tables, not built here
    );

    commit_cu u_commit_cu (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .comm_valid_i         (comm_valid_o),
        .comm_except_raised_i (comm_except_raised),
        .comm_ready_o         (comm_ready),
        .rf_we_o              (rf_we),
        .trap_we_o            (trap_we),
        .flush_o              (flush)
    );

    arch_state u_arch_state (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rf_we_i       (rf_we),
        .rf_rd_idx_i   (comm_rd_idx),
        .rf_value_i    (comm_value),
        .trap_we_i     (trap_we),
        .trap_code_i   (comm_except_code),
        .trap_pc_i     (comm_pc),
        .rf_rs_idx_i   (rf_rs_idx_i),
        .rf_rs_value_o (rf_rs_value_o),
        .trap_valid_o  (trap_valid_o),
        .trap_cause_o  (trap_cause_o),
        .trap_pc_o     (trap_pc_o),
        .trap_aux_o    (trap_aux_o)
    );

endmodule

//--- logic/commit_cu.sv
/*
 * Commit FSM. Retires the head entry into the register file or the
 * trap record, and follows an exception with a one-cycle flush
 */
`timescale 1ns/100ps
`include "len5_config.svh"

module commit_cu (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic comm_valid_i,          // Head entry complete
    input  logic comm_except_raised_i,  // Head entry trapped
    output logic comm_ready_o,
    output logic rf_we_o,
    output logic trap_we_o,
    output logic flush_o
);

    typedef enum logic {
        RUN,
        FLUSH
    } state_t;

    state_t state, next_state;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= RUN;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RUN: begin
                if (comm_valid_i && comm_except_raised_i) begin
                    next_state = FLUSH;     // Trap retired, drop the rest
                end
            end
            FLUSH: next_state = RUN;        // Single flush cycle
            default: next_state = RUN;
        endcase
    end

    // Outputs
    assign comm_ready_o = (state == RUN);   // Every complete head is taken in RUN
    assign rf_we_o      = comm_ready_o && comm_valid_i && !comm_except_raised_i;
    assign trap_we_o    = comm_ready_o && comm_valid_i && comm_except_raised_i;
    assign flush_o      = (state == FLUSH);

    generate
        if (`LEN5_ASSERT_EN) begin : g_assert
            // Nothing younger than the trap survives to the head
            a_flush_drains: assert property (
                @(posedge clk_i) disable iff (!rst_n_i) flush_o |=> !comm_valid_i
            ) else $error("commit_cu: head still complete after a flush");
        end
    endgenerate

endmodule

//--- logic/modn_counter.sv
/*
 * Modulo-N up counter with count enable and synchronous clear
 */
`timescale 1ns/100ps
`include "len5_config.svh"

module modn_counter #(
    parameter int N = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 clr_i,     // Wins over en_i
    output logic [$clog2(N)-1:0] count_o
);

    localparam int CW = $clog2(N);
    localparam logic [CW-1:0] LAST = CW'(N - 1);    // Wrap point

    // --------------------
    // Count register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;
        end else if (en_i) begin
            if (count_o == LAST) begin
                count_o <= '0;              // Wrap back to 0
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

    // Relevant when N is not a power of two
    generate
        if (`LEN5_ASSERT_EN) begin : g_assert
            a_count_range: assert property (
                @(posedge clk_i) disable iff (!rst_n_i) count_o < N
            ) else $error("modn_counter: count %0d out of range", count_o);
        end
    endgenerate

endmodule

//--- rob/rob.sv
/*
 * Reorder buffer. Allocates entries in program order, collects results
 * from the CDB, forwards operands to issue and presents the head to commit
 */
`timescale 1ns/100ps
`include "len5_config.svh"

module rob #(
    parameter int ROB_DEPTH   = 8,
    parameter int ROB_IDX_LEN = 3
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,           // Drop every entry

    input  logic                             issue_valid_i,
    output logic                             issue_ready_o,

    input  logic [ROB_IDX_LEN-1:0]           issue_rs1_idx_i,
    input  logic [ROB_IDX_LEN-1:0]           issue_rs2_idx_i,
    output logic                             issue_rs1_ready_o,
    output logic                             issue_rs2_ready_o,
    output logic [len5_pkg::XLEN-1:0]        issue_rs1_value_o,
    output logic [len5_pkg::XLEN-1:0]        issue_rs2_value_o,

    input  len5_pkg::instr_t                 issue_instr_i,
    input  logic [len5_pkg::XLEN-1:0]        issue_pc_i,
    input  logic [len5_pkg::REG_IDX_LEN-1:0] issue_rd_idx_i,
    input  logic                             issue_except_raised_i,
    input  expipe_pkg::except_code_t         issue_except_code_i,
    input  logic [len5_pkg::XLEN-1:0]        issue_except_aux_i,    // Offending address
    input  logic                             issue_res_ready_i,     // Complete at issue
    input  logic [len5_pkg::XLEN-1:0]        issue_res_value_i,
    output logic [ROB_IDX_LEN-1:0]           issue_tail_idx_o,      // Slot being allocated

    input  logic                             cdb_valid_i,
    input  expipe_pkg::cdb_data_t            cdb_data_i,

    input  logic                             comm_ready_i,
    output logic                             comm_valid_o,
    output len5_pkg::instr_t                 comm_instr_o,
    output logic [len5_pkg::XLEN-1:0]        comm_pc_o,
    output logic [len5_pkg::REG_IDX_LEN-1:0] comm_rd_idx_o,
    output expipe_pkg::res_word_u            comm_value_o,
    output logic                             comm_except_raised_o,
    output expipe_pkg::except_code_t         comm_except_code_o,
    output logic [ROB_IDX_LEN-1:0]           comm_head_idx_o
);

    import expipe_pkg::*;

    rob_entry_t               rob_data [ROB_DEPTH];     // Circular entry array
    logic [ROB_DEPTH-1:0]     valid_a;                  // Valid bits, gathered
    logic [ROB_IDX_LEN-1:0]   head_idx, tail_idx;
    logic [ROB_IDX_LEN-1:0]   cdb_idx;
    logic                     push, pop;

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            valid_a[i] = rob_data[i].valid;
        end
    end

    assign cdb_idx = cdb_data_i.rob_idx[ROB_IDX_LEN-1:0];  // Drop unused high bits

    // --------------------
    // Control
    // --------------------
    assign issue_ready_o = !rob_data[tail_idx].valid && !flush_i;  // Free tail slot
    assign push          = issue_valid_i && issue_ready_o;
    assign comm_valid_o  = rob_data[head_idx].valid && rob_data[head_idx].res_ready;
    assign pop           = comm_valid_o && comm_ready_i;

    // --------------------
    // Entry update
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            foreach (rob_data[i]) begin
                rob_data[i].valid         <= 1'b0;
                rob_data[i].res_ready     <= 1'b0;
                rob_data[i].except_raised <= 1'b0;
            end
        end else if (flush_i) begin
            // Status bits only, payload is dead once valid drops
            foreach (rob_data[i]) begin
                rob_data[i].valid         <= 1'b0;
                rob_data[i].res_ready     <= 1'b0;
                rob_data[i].except_raised <= 1'b0;
            end
        end else begin
            if (push) begin
                rob_data[tail_idx].valid         <= 1'b1;
                rob_data[tail_idx].instruction   <= issue_instr_i;
                rob_data[tail_idx].pc            <= issue_pc_i;
                rob_data[tail_idx].rd_idx        <= issue_rd_idx_i;
                rob_data[tail_idx].except_raised <= issue_except_raised_i;
                if (issue_except_raised_i) begin
                    rob_data[tail_idx].res.aux     <= issue_except_aux_i;
                    rob_data[tail_idx].except_code <= issue_except_code_i;
                    rob_data[tail_idx].res_ready   <= 1'b1;     // Straight to commit
                end else if (issue_res_ready_i) begin
                    rob_data[tail_idx].res.result  <= issue_res_value_i;
                    rob_data[tail_idx].res_ready   <= 1'b1;
                end else begin
                    rob_data[tail_idx].res_ready   <= 1'b0;     // Waits for the CDB
                end
            end
            if (cdb_valid_i) begin
                rob_data[cdb_idx].res           <= cdb_data_i.res;
                rob_data[cdb_idx].except_raised <= cdb_data_i.except_raised;
                rob_data[cdb_idx].except_code   <= cdb_data_i.except_code;
                rob_data[cdb_idx].res_ready     <= 1'b1;
            end
            if (pop) begin
                rob_data[head_idx].valid <= 1'b0;
            end
        end
    end

    // Head and tail pointers, both reset by a flush
    modn_counter #(.N(ROB_DEPTH)) head_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (pop),
        .clr_i   (flush_i),
        .count_o (head_idx)
    );

    modn_counter #(.N(ROB_DEPTH)) tail_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (push),
        .clr_i   (flush_i),
        .count_o (tail_idx)
    );

    // --------------------
    // Read ports
    // --------------------
    assign issue_rs1_ready_o = rob_data[issue_rs1_idx_i].valid
                             && rob_data[issue_rs1_idx_i].res_ready;
    assign issue_rs2_ready_o = rob_data[issue_rs2_idx_i].valid
                             && rob_data[issue_rs2_idx_i].res_ready;
    assign issue_rs1_value_o = rob_data[issue_rs1_idx_i].res.result;
    assign issue_rs2_value_o = rob_data[issue_rs2_idx_i].res.result;
    assign issue_tail_idx_o  = tail_idx;

    // Head entry to commit
    assign comm_instr_o         = rob_data[head_idx].instruction;
    assign comm_pc_o            = rob_data[head_idx].pc;
    assign comm_rd_idx_o        = rob_data[head_idx].rd_idx;
    assign comm_value_o         = rob_data[head_idx].res;
    assign comm_except_raised_o = rob_data[head_idx].except_raised;
    assign comm_except_code_o   = rob_data[head_idx].except_code;
    assign comm_head_idx_o      = head_idx;

    generate
        if (`LEN5_ASSERT_EN) begin : g_assert
            // Results only go to instructions still in flight
            a_cdb_target: assert property (
                @(posedge clk_i) disable iff (!rst_n_i || flush_i)
                cdb_valid_i |-> valid_a[cdb_idx]
            ) else $error("rob: CDB write to free entry %0d", cdb_idx);
            // Pointer state agrees with the valid bits, a full buffer has them met
            a_full_ptrs: assert property (
                @(posedge clk_i) disable iff (!rst_n_i) &valid_a |-> (head_idx == tail_idx)
            ) else $error("rob: full buffer with head %0d and tail %0d apart",
                          head_idx, tail_idx);
        end
    endgenerate

endmodule

//--- run.sh
#!/bin/sh
# Build the back-end testbench with Verilator, run it and judge the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_backend -f all.f || exit 1
output="$(./obj_dir/Vtb_backend 2>&1)"
echo "$output"
echo "$output" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
